// File: design/wasm_params.svh
`ifndef WASM_PARAMS_SVH
`define WASM_PARAMS_SVH

`default_nettype none

// Number of slots in the operand stack
`define STACK_DEPTH 8

// Payload width of one stack entry
`define VALUE_W 64

// Instruction opcode width
`define OPCODE_W 8

`default_nettype wire

`endif

// File: design/wasm_value_pkg.sv
`include "wasm_params.svh"

`default_nettype none

package wasm_value_pkg;

  typedef logic [`VALUE_W-1:0] word64_t;
  typedef logic [31:0]         word32_t;

  // Operand type tag carried next to each payload
  // f32 and f64 keep their codes but nothing produces them
  typedef enum logic [1:0] {
    vt_i32 = 2'd0,
    vt_i64 = 2'd1,
    vt_f32 = 2'd2,
    vt_f64 = 2'd3
  } value_type_t;

  // Occupancy from 0 up to a full stack
  typedef logic [$clog2(`STACK_DEPTH+1)-1:0] stack_count_t;

endpackage

`default_nettype wire

// File: design/wasm_ctrl_pkg.sv
`include "wasm_params.svh"

`default_nettype none

package wasm_ctrl_pkg;

  // WebAssembly binary opcodes of the supported subset
  typedef enum logic [`OPCODE_W-1:0] {
    op_unreachable = 8'h00,
    op_nop         = 8'h01,
    op_end         = 8'h0b,
    op_drop        = 8'h1a,
    op_i32_const   = 8'h41,
    op_i64_const   = 8'h42,
    op_i32_eqz     = 8'h45,
    op_i32_eq      = 8'h46,
    op_i32_ne      = 8'h47,
    op_i64_eqz     = 8'h50,
    op_i64_eq      = 8'h51,
    op_i64_ne      = 8'h52,
    op_i32_add     = 8'h6a,
    op_i32_sub     = 8'h6b,
    op_i64_add     = 8'h7c,
    op_i64_sub     = 8'h7d
  } opcode_t;

  // Sticky trap code that stays none while the core runs
  typedef enum logic [2:0] {
    trap_none           = 3'd0,
    trap_ended          = 3'd1,
    trap_unreachable    = 3'd2,
    trap_type_mismatch  = 3'd3,
    trap_stack_empty    = 3'd4,
    trap_stack_overflow = 3'd5,
    trap_unknown_opcode = 3'd6
  } trap_t;

  // Shift operation applied to all slots in one cycle
  typedef enum logic [2:0] {
    sop_hold        = 3'd0,
    sop_push        = 3'd1,
    sop_pop         = 3'd2,
    sop_replace     = 3'd3,
    sop_pop_replace = 3'd4
  } stack_op_t;

endpackage

`default_nettype wire

// File: design/stack_slot.sv
`default_nettype none

module stack_slot
  import wasm_value_pkg::*, wasm_ctrl_pkg::*;
#(
  parameter bit is_top = 1'b0
) (
  input  logic        clk,
  input  logic        reset,
  input  stack_op_t   stack_op,
  input  word64_t     new_value,
  input  value_type_t new_type,
  input  word64_t     above_value,
  input  value_type_t above_type,
  input  logic        above_valid,
  input  word64_t     below_value,
  input  value_type_t below_type,
  input  logic        below_valid,
  input  word64_t     below2_value,
  input  value_type_t below2_type,
  input  logic        below2_valid,
  output word64_t     value,
  output value_type_t vtype,
  output logic        valid
);

  word64_t     next_value;
  value_type_t next_type;
  logic        next_valid;

  always_comb begin
    next_value = value;
    next_type  = vtype;
    next_valid = valid;
    case (stack_op)
      sop_push: begin
        // Everything moves one slot deeper
        next_value = is_top ? new_value : above_value;
        next_type  = is_top ? new_type  : above_type;
        next_valid = is_top ? 1'b1      : above_valid;
      end
      sop_pop: begin
        next_value = below_value;
        next_type  = below_type;
        next_valid = below_valid;
      end
      sop_replace: begin
        if (is_top) begin
          next_value = new_value;
          next_type  = new_type;
        end
      end
      sop_pop_replace: begin
        // Two operands leave and the result lands on top
        next_value = is_top ? new_value : below2_value;
        next_type  = is_top ? new_type  : below2_type;
        next_valid = is_top ? 1'b1      : below2_valid;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    value <= next_value;
    vtype <= next_type;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= next_valid;
    end
  end

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`include "wasm_params.svh"

`default_nettype none

module exec_unit
  import wasm_value_pkg::*, wasm_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         instr_valid,
  input  opcode_t      opcode,
  input  word64_t      imm,
  input  word64_t      top_value,
  input  value_type_t  top_type,
  input  word64_t      next_value,
  input  value_type_t  next_type,
  input  stack_count_t depth,
  output stack_op_t    stack_op,
  output word64_t      new_value,
  output value_type_t  new_type,
  output trap_t        trap
);

  logic        known;
  logic        typed;
  logic [1:0]  operands;
  value_type_t op_type;
  stack_op_t   exec_op;
  trap_t       op_trap;
  trap_t       check_trap;
  logic        accept;
  word32_t     top_lo;
  word32_t     next_lo;

  assign top_lo  = top_value[31:0];
  assign next_lo = next_value[31:0];

  // Opcode decode and result datapath
  always_comb begin
    known     = 1'b1;
    typed     = 1'b1;
    operands  = 2'd0;
    op_type   = vt_i32;
    exec_op   = sop_hold;
    op_trap   = trap_none;
    new_value = '0;
    new_type  = vt_i32;
    case (opcode)
      op_unreachable: op_trap = trap_unreachable;
      op_nop:         ;
      op_end:         op_trap = trap_ended;
      op_drop: begin
        // Any operand type may be dropped
        typed    = 1'b0;
        operands = 2'd1;
        exec_op  = sop_pop;
      end
      op_i32_const: begin
        exec_op   = sop_push;
        new_value = {32'b0, imm[31:0]};
      end
      op_i64_const: begin
        exec_op   = sop_push;
        new_value = imm;
        new_type  = vt_i64;
      end
      op_i32_eqz: begin
        operands  = 2'd1;
        exec_op   = sop_replace;
        new_value = 64'(top_lo == 32'd0);
      end
      op_i64_eqz: begin
        operands  = 2'd1;
        op_type   = vt_i64;
        exec_op   = sop_replace;
        new_value = 64'(top_value == 64'd0);
      end
      op_i32_eq, op_i32_ne: begin
        operands  = 2'd2;
        exec_op   = sop_pop_replace;
        new_value = 64'((next_lo == top_lo) ^ (opcode == op_i32_ne));
      end
      op_i64_eq, op_i64_ne: begin
        operands  = 2'd2;
        op_type   = vt_i64;
        exec_op   = sop_pop_replace;
        new_value = 64'((next_value == top_value) ^ (opcode == op_i64_ne));
      end
      op_i32_add: begin
        operands  = 2'd2;
        exec_op   = sop_pop_replace;
        new_value = {32'b0, next_lo + top_lo};
      end
      op_i32_sub: begin
        operands  = 2'd2;
        exec_op   = sop_pop_replace;
        new_value = {32'b0, next_lo - top_lo};
      end
      op_i64_add: begin
        operands  = 2'd2;
        op_type   = vt_i64;
        exec_op   = sop_pop_replace;
        new_value = next_value + top_value;
        new_type  = vt_i64;
      end
      op_i64_sub: begin
        operands  = 2'd2;
        op_type   = vt_i64;
        exec_op   = sop_pop_replace;
        new_value = next_value - top_value;
        new_type  = vt_i64;
      end
      default: known = 1'b0;
    endcase
  end

  // Trap checks in priority order
  always_comb begin
    if (!known) begin
      check_trap = trap_unknown_opcode;
    end else if (stack_count_t'(operands) > depth) begin
      check_trap = trap_stack_empty;
    end else if (exec_op == sop_push && depth == stack_count_t'(`STACK_DEPTH)) begin
      check_trap = trap_stack_overflow;
    end else if (typed && operands != 2'd0 &&
                 (top_type != op_type || (operands == 2'd2 && next_type != op_type))) begin
      check_trap = trap_type_mismatch;
    end else begin
      check_trap = op_trap;
    end
  end

  assign accept   = instr_valid && (trap == trap_none);
  assign stack_op = (accept && check_trap == trap_none) ? exec_op : sop_hold;

  // First trap sticks until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      trap <= trap_none;
    end else if (accept) begin
      trap <= check_trap;
    end
  end

endmodule

`default_nettype wire

// File: design/stack_top_reader.sv
`include "wasm_params.svh"

`default_nettype none

module stack_top_reader
  import wasm_value_pkg::*;
(
  input  word64_t                 slot_value [`STACK_DEPTH],
  input  value_type_t             slot_type  [`STACK_DEPTH],
  input  logic [`STACK_DEPTH-1:0] slot_valid,
  output word64_t                 top_value,
  output value_type_t             top_type,
  output word64_t                 next_value,
  output value_type_t             next_type,
  output stack_count_t            depth,
  output word64_t                 result,
  output value_type_t             result_type,
  output logic                    result_empty
);

  // Occupancy is the number of valid slots
  always_comb begin
    depth = '0;
    for (int i = 0; i < `STACK_DEPTH; i++) begin
      depth = depth + stack_count_t'(slot_valid[i]);
    end
  end

  assign top_value  = slot_value[0];
  assign top_type   = slot_type[0];
  assign next_value = slot_value[1];
  assign next_type  = slot_type[1];

  // Empty stack reads as i32 zero
  assign result_empty = !slot_valid[0];
  assign result       = slot_valid[0] ? slot_value[0] : '0;
  assign result_type  = slot_valid[0] ? slot_type[0]  : vt_i32;

endmodule

`default_nettype wire

// File: design/wasm_core.sv
`include "wasm_params.svh"

`default_nettype none

module wasm_core
  import wasm_value_pkg::*, wasm_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         instr_valid,
  input  opcode_t      opcode,
  input  word64_t      imm,
  output word64_t      result,
  output value_type_t  result_type,
  output logic         result_empty,
  output stack_count_t depth,
  output trap_t        trap
);

  stack_op_t   stack_op;
  word64_t     new_value;
  value_type_t new_type;
  word64_t     top_value;
  value_type_t top_type;
  word64_t     next_value;
  value_type_t next_type;

  word64_t                 slot_value [`STACK_DEPTH];
  value_type_t             slot_type  [`STACK_DEPTH];
  logic [`STACK_DEPTH-1:0] slot_valid;

  // Slot i sits at index i+1, with one empty entry above and two below
  word64_t                 pad_value [`STACK_DEPTH+3];
  value_type_t             pad_type  [`STACK_DEPTH+3];
  logic [`STACK_DEPTH+2:0] pad_valid;

  exec_unit u_exec (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .opcode      (opcode),
    .imm         (imm),
    .top_value   (top_value),
    .top_type    (top_type),
    .next_value  (next_value),
    .next_type   (next_type),
    .depth       (depth),
    .stack_op    (stack_op),
    .new_value   (new_value),
    .new_type    (new_type),
    .trap        (trap)
  );

  for (genvar j = 0; j < `STACK_DEPTH + 3; j++) begin : g_pad
    if (j >= 1 && j <= `STACK_DEPTH) begin : g_slot
      assign pad_value[j] = slot_value[j-1];
      assign pad_type[j]  = slot_type[j-1];
      assign pad_valid[j] = slot_valid[j-1];
    end else begin : g_edge
      assign pad_value[j] = '0;
      assign pad_type[j]  = vt_i32;
      assign pad_valid[j] = 1'b0;
    end
  end

  for (genvar i = 0; i < `STACK_DEPTH; i++) begin : g_stack
    stack_slot #(
      .is_top (i == 0)
    ) u_slot (
      .clk          (clk),
      .reset        (reset),
      .stack_op     (stack_op),
      .new_value    (new_value),
      .new_type     (new_type),
      .above_value  (pad_value[i]),
      .above_type   (pad_type[i]),
      .above_valid  (pad_valid[i]),
      .below_value  (pad_value[i+2]),
      .below_type   (pad_type[i+2]),
      .below_valid  (pad_valid[i+2]),
      .below2_value (pad_value[i+3]),
      .below2_type  (pad_type[i+3]),
      .below2_valid (pad_valid[i+3]),
      .value        (slot_value[i]),
      .vtype        (slot_type[i]),
      .valid        (slot_valid[i])
    );
  end

  stack_top_reader u_reader (
    .slot_value   (slot_value),
    .slot_type    (slot_type),
    .slot_valid   (slot_valid),
    .top_value    (top_value),
    .top_type     (top_type),
    .next_value   (next_value),
    .next_type    (next_type),
    .depth        (depth),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty)
  );

endmodule

`default_nettype wire

// File: tests/wasm_core_checker.sv
`default_nettype none

module wasm_core_checker
  import wasm_value_pkg::*, wasm_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         check_en,
  input  int           vec_index,
  input  logic [63:0]  exp_result,
  input  logic [1:0]   exp_type,
  input  logic         exp_empty,
  input  stack_count_t exp_depth,
  input  logic [2:0]   exp_trap,
  input  word64_t      result,
  input  value_type_t  result_type,
  input  logic         result_empty,
  input  stack_count_t depth,
  input  trap_t        trap,
  output int           check_count,
  output int           error_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic         armed = 1'b0;
  int           idx_q = 0;
  logic [63:0]  want_result;
  logic [1:0]   want_type;
  logic         want_empty;
  stack_count_t want_depth;
  logic [2:0]   want_trap;
  int           checks = 0;
  int           errors = 0;

  assign check_count = checks;
  assign error_count = errors;

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    if (got !== want) begin
      errors++;
      $display("ERROR: %s is 0x%0h, expected 0x%0h (vector %0d)", name, got, want, idx_q);
    end
  endtask

  // Expected values of the instruction sampled at this edge
  always @(posedge clk) begin
    armed       <= check_en;
    idx_q       <= vec_index;
    want_result <= exp_result;
    want_type   <= exp_type;
    want_empty  <= exp_empty;
    want_depth  <= exp_depth;
    want_trap   <= exp_trap;
  end

  // Outputs have settled by the falling edge
  always @(negedge clk) begin
    if (armed) begin
      checks++;
      compare_field("result", result, want_result);
      compare_field("result_type", result_type, want_type);
      compare_field("result_empty", result_empty, want_empty);
      compare_field("depth", depth, want_depth);
      compare_field("trap", trap, want_trap);
    end
  end

endmodule

`default_nettype wire

// File: tests/wasm_core_props.sv
`default_nettype none

module wasm_core_props
  import wasm_value_pkg::*, wasm_ctrl_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input logic         result_empty,
  input stack_count_t depth,
  input trap_t        trap
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // A trap keeps its code until the next reset
  trap_sticky: assert property (@(posedge clk)
    (!reset && trap != trap_none) |=> (trap == $past(trap)))
    else begin
      fail_count++;
      $error("trap code changed without a reset");
    end

  empty_flag: assert property (@(posedge clk) disable iff (reset)
    result_empty == (depth == '0))
    else begin
      fail_count++;
      $error("result_empty disagrees with depth");
    end

  // Reset clears the trap by the next cycle
  trap_after_reset: assert property (@(posedge clk) reset |=> (trap == trap_none))
    else begin
      fail_count++;
      $error("trap not cleared after reset");
    end

endmodule

bind wasm_core wasm_core_props props_inst (
  .clk          (clk),
  .reset        (reset),
  .result_empty (result_empty),
  .depth        (depth),
  .trap         (trap)
);

`default_nettype wire

// File: tests/wasm_core_tb.sv
`default_nettype none

module wasm_core_tb
  import wasm_value_pkg::*, wasm_ctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam string VECTOR_FILE = "tests/wasm_core_vectors.txt";

  logic         clk;
  logic         reset;
  logic         instr_valid;
  opcode_t      opcode;
  word64_t      imm;
  word64_t      result;
  value_type_t  result_type;
  logic         result_empty;
  stack_count_t depth;
  trap_t        trap;

  logic         check_en;
  int           vec_index;
  logic [63:0]  exp_result;
  logic [1:0]   exp_type;
  logic         exp_empty;
  stack_count_t exp_depth;
  logic [2:0]   exp_trap;
  int           check_count;
  int           error_count;
  int           load_errors = 0;
  logic         loaded = 1'b0;

  // One entry per vector line
  logic         vec_reset [$];
  logic         vec_valid [$];
  logic [7:0]   vec_opcode [$];
  logic [63:0]  vec_imm [$];
  logic [63:0]  vec_result [$];
  logic [1:0]   vec_type [$];
  logic         vec_empty [$];
  stack_count_t vec_depth [$];
  logic [2:0]   vec_trap [$];

  wasm_core wasm_core_inst (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .opcode       (opcode),
    .imm          (imm),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .depth        (depth),
    .trap         (trap)
  );

  wasm_core_checker compare_inst (
    .clk          (clk),
    .check_en     (check_en),
    .vec_index    (vec_index),
    .exp_result   (exp_result),
    .exp_type     (exp_type),
    .exp_empty    (exp_empty),
    .exp_depth    (exp_depth),
    .exp_trap     (exp_trap),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .depth        (depth),
    .trap         (trap),
    .check_count  (check_count),
    .error_count  (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic load_vectors();
    int           fd;
    int           fields;
    string        line;
    logic         r;
    logic         v;
    logic         e;
    logic [7:0]   op;
    logic [63:0]  im;
    logic [63:0]  res;
    logic [1:0]   t;
    stack_count_t d;
    logic [2:0]   tr;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VECTOR_FILE);
      load_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                       r, v, op, im, res, t, e, d, tr);
      if (fields != 9) begin
        $display("Malformed line in the vector file: %s", line);
        load_errors++;
      end else begin
        vec_reset.push_back(r);
        vec_valid.push_back(v);
        vec_opcode.push_back(op);
        vec_imm.push_back(im);
        vec_result.push_back(res);
        vec_type.push_back(t);
        vec_empty.push_back(e);
        vec_depth.push_back(d);
        vec_trap.push_back(tr);
      end
    end
    $fclose(fd);
    if (vec_reset.size() == 0) begin
      $display("The vector file holds no vectors");
      load_errors++;
    end
  endtask

  task automatic apply_vector(input int k);
    reset       = vec_reset[k];
    instr_valid = vec_valid[k];
    opcode      = opcode_t'(vec_opcode[k]);
    imm         = vec_imm[k];
    exp_result  = vec_result[k];
    exp_type    = vec_type[k];
    exp_empty   = vec_empty[k];
    exp_depth   = vec_depth[k];
    exp_trap    = vec_trap[k];
    vec_index   = k;
    check_en    = 1'b1;
  endtask

  initial begin
    int total;
    reset       = 1'b1;
    instr_valid = 1'b0;
    opcode      = op_nop;
    imm         = '0;
    check_en    = 1'b0;
    vec_index   = 0;
    exp_result  = '0;
    exp_type    = '0;
    exp_empty   = 1'b1;
    exp_depth   = '0;
    exp_trap    = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #5;
    for (int k = 0; k < vec_reset.size(); k++) begin
      apply_vector(k);
      @(posedge clk);
      #5;
    end
    reset       = 1'b0;
    instr_valid = 1'b0;
    check_en    = 1'b0;
    // Let the checker finish the last vector
    @(negedge clk);
    #1;
    total = error_count + wasm_core_inst.props_inst.fail_count + load_errors;
    if (check_count != vec_reset.size()) begin
      $display("Only %0d of %0d vectors were checked", check_count, vec_reset.size());
      total++;
    end
    $display("Vectors: %0d, checks: %0d, data errors: %0d, assertion errors: %0d, total: %0d",
             vec_reset.size(), check_count, error_count,
             wasm_core_inst.props_inst.fail_count, total);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the number of vectors
  initial begin
    wait (loaded);
    #((vec_reset.size() + 10) * 100);
    $display("The run timed out before all vectors were applied");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/wasm_core_vectors.txt
# reset valid opcode imm | expected result type empty depth trap (all hex)
# expected columns hold the DUT outputs after the next rising clock edge
0 1 41 0000000512345678 0000000012345678 0 0 1 0
0 1 42 1122334455667788 1122334455667788 1 0 2 0
0 1 1a 0 0000000012345678 0 0 1 0
0 1 01 0 0000000012345678 0 0 1 0
0 0 42 ffffffffffffffff 0000000012345678 0 0 1 0
0 1 1a 0 0 0 1 0 0
0 1 41 ffffffff 00000000ffffffff 0 0 1 0
0 1 41 1 1 0 0 2 0
0 1 6a 0 0 0 0 1 0
0 1 41 5 5 0 0 2 0
0 1 6b 0 00000000fffffffb 0 0 1 0
0 1 1a 0 0 0 1 0 0
0 1 42 ffffffffffffffff ffffffffffffffff 1 0 1 0
0 1 42 2 2 1 0 2 0
0 1 7c 0 1 1 0 1 0
0 1 42 10 10 1 0 2 0
0 1 7d 0 fffffffffffffff1 1 0 1 0
0 1 50 0 0 0 0 1 0
0 1 45 0 1 0 0 1 0
0 1 41 1 1 0 0 2 0
0 1 46 0 1 0 0 1 0
0 1 41 7 7 0 0 2 0
0 1 47 0 1 0 0 1 0
0 1 1a 0 0 0 1 0 0
0 1 42 123456789abcdef0 123456789abcdef0 1 0 1 0
0 1 42 123456789abcdef0 123456789abcdef0 1 0 2 0
0 1 51 0 1 0 0 1 0
0 1 1a 0 0 0 1 0 0
0 1 42 5 5 1 0 1 0
0 1 42 6 6 1 0 2 0
0 1 52 0 1 0 0 1 0
0 1 42 0 0 1 0 2 0
0 1 50 0 1 0 0 2 0
0 1 42 5 5 1 0 3 0
0 1 52 0 5 1 0 3 3
0 1 1a 0 5 1 0 3 3
1 0 00 0 0 0 1 0 0
0 1 1a 0 0 0 1 0 4
1 0 00 0 0 0 1 0 0
0 1 41 1 1 0 0 1 0
0 1 41 2 2 0 0 2 0
0 1 41 3 3 0 0 3 0
0 1 41 4 4 0 0 4 0
0 1 41 5 5 0 0 5 0
0 1 41 6 6 0 0 6 0
0 1 41 7 7 0 0 7 0
0 1 41 8 8 0 0 8 0
0 1 42 9 8 0 0 8 5
1 0 00 0 0 0 1 0 0
0 1 01 0 0 0 1 0 0
0 1 0b 0 0 0 1 0 1
0 1 01 0 0 0 1 0 1
1 0 00 0 0 0 1 0 0
0 1 ff 0 0 0 1 0 6
1 0 00 0 0 0 1 0 0
0 1 00 0 0 0 1 0 2

// File: tb.f
+incdir+design
design/wasm_value_pkg.sv
design/wasm_ctrl_pkg.sv
design/stack_slot.sv
design/exec_unit.sv
design/stack_top_reader.sv
design/wasm_core.sv
tests/wasm_core_checker.sv
tests/wasm_core_props.sv
tests/wasm_core_tb.sv

// File: Bender.yml
package:
  name: wasm_core

export_include_dirs:
  - design

sources:
  - design/wasm_value_pkg.sv
  - design/wasm_ctrl_pkg.sv
  - design/stack_slot.sv
  - design/exec_unit.sv
  - design/stack_top_reader.sv
  - design/wasm_core.sv
  - target: test
    files:
      - tests/wasm_core_checker.sv
      - tests/wasm_core_props.sv
      - tests/wasm_core_tb.sv
